/* Bender.yml */
package:
  name: sw_align

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/sw_pkg.sv
      - design/symbol_intake.sv
      - design/pe_cell.sv
      - design/pe_array.sv
      - design/wavefront_max.sv
      - design/score_max_tracker.sv
      - design/sw_align_top.sv
  - target: test
    include_dirs:
      - design
      - bench
    files:
      - bench/sw_align_tb.sv

/* bench/sw_align_tb_model.svh */
`ifndef SW_ALIGN_TB_MODEL_SVH
`define SW_ALIGN_TB_MODEL_SVH

// one Galois step, taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
endfunction

// n fresh bits, one LFSR step per bit
function automatic int draw_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
        v = (v << 1) | int'(lfsr_state[0]);
        lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
endfunction

function automatic int larger_of(input int a, input int b);
    return (a > b) ? a : b;
endfunction

// full Gotoh matrix over ref_buf[0..len-1]
function automatic void align_reference(input query_t q, input int len, output int best,
                                        output int best_row, output int best_col);
    int   h [0:MAX_LEN][0:`SW_NUM_PE];
    int   e [0:MAX_LEN][0:`SW_NUM_PE];
    int   f [0:MAX_LEN][0:`SW_NUM_PE];
    int   s;
    logic later;
    best     = `SW_NEG_INF;
    best_row = 0;
    best_col = 0;
    h[0][0]  = 0;
    for (int k = 1; k <= len; k++) begin
        h[k][0] = `SW_GAP_OPEN + `SW_GAP_EXTEND * (k - 1);
        e[k][0] = `SW_NEG_INF;
    end
    for (int k = 1; k <= `SW_NUM_PE; k++) begin
        h[0][k] = `SW_GAP_OPEN + `SW_GAP_EXTEND * (k - 1);
        f[0][k] = `SW_NEG_INF;
    end
    for (int r = 1; r <= len; r++) begin
        for (int c = 1; c <= `SW_NUM_PE; c++) begin
            s = (q[(c - 1) * `SW_BASE_W +: `SW_BASE_W] == ref_buf[r - 1]) ?
                `SW_MATCH : `SW_MISMATCH;
            e[r][c] = larger_of(e[r][c - 1] + `SW_GAP_EXTEND, h[r][c - 1] + `SW_GAP_OPEN);
            f[r][c] = larger_of(f[r - 1][c] + `SW_GAP_EXTEND, h[r - 1][c] + `SW_GAP_OPEN);
            h[r][c] = larger_of(h[r - 1][c - 1] + s, larger_of(e[r][c], f[r][c]));
            // later wavefront step first, then higher column
            later = (r + c > best_row + best_col) ||
                    ((r + c == best_row + best_col) && (c > best_col));
            if ((h[r][c] > best) || ((h[r][c] == best) && later)) begin
                best     = h[r][c];
                best_row = r;
                best_col = c;
            end
        end
    end
endfunction

task automatic check_value(input string what, input int expected, input int actual);
    n_checks++;
    if (expected != actual) begin
        n_errors++;
        $display("mismatch %s: expected %0d, actual %0d", what, expected, actual);
    end
endtask

task automatic report_failure(input string what);
    n_errors++;
    $display("error at %0t: %s", $time, what);
endtask

`endif

/* bench/sw_align_tb.sv */
`default_nettype none

`include "sw_consts.svh"

module sw_align_tb;

    import sw_pkg::*;

    localparam int CLK_PERIOD     = 20;
    localparam int DRIVE_DELAY    = 2;
    localparam int MAX_LEN        = 60;
    localparam int N_RANDOM       = 12;
    localparam int N_RUNS         = N_RANDOM + 5;
    localparam int TIMEOUT_CYCLES = N_RUNS * (MAX_LEN * 8 + `SW_NUM_PE + 20);

    logic        i_clk;
    logic        i_rst;
    logic        i_start;
    query_t      i_query;
    logic        i_sym_req;
    base_t       i_sym;
    logic        i_sym_last;
    logic        o_sym_ack;
    logic        o_busy;
    logic        o_done;
    score_t      o_max_score;
    pos_t        o_max_row;
    col_t        o_max_col;

    logic [31:0] lfsr_state;
    base_t       ref_buf [MAX_LEN];
    int          n_errors = 0;
    int          n_checks = 0;
    // expected results, oldest run first
    string       exp_name [$];
    int          exp_score [$];
    int          exp_row [$];
    int          exp_col [$];

    `include "sw_align_tb_model.svh"

    sw_align_top u_dut (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (i_start),
        .i_query     (i_query),
        .i_sym_req   (i_sym_req),
        .i_sym       (i_sym),
        .i_sym_last  (i_sym_last),
        .o_sym_ack   (o_sym_ack),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_max_score (o_max_score),
        .o_max_row   (o_max_row),
        .o_max_col   (o_max_col)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    task automatic next_cycle();
        @(posedge i_clk);
        #(DRIVE_DELAY);
    endtask

    task automatic wait_for_done();
        do begin
            @(negedge i_clk);
        end while (!o_done);
        next_cycle();
    endtask

    // four-phase transfer of one base, up to 8 cycles
    task automatic send_symbol(input base_t b, input logic last, input logic slow);
        int hold;
        hold = slow ? draw_bits(2) : 0;
        repeat (hold) next_cycle();
        i_sym      = b;
        i_sym_last = last;
        i_sym_req  = 1'b1;
        do begin
            next_cycle();
        end while (!o_sym_ack);
        hold = slow ? draw_bits(2) : 0;
        repeat (hold) next_cycle();
        i_sym_req = 1'b0;
        do begin
            next_cycle();
        end while (o_sym_ack);
    endtask

    task automatic probe_idle_request();
        i_sym_req = 1'b1;
        repeat (10) begin
            next_cycle();
            if (o_sym_ack) begin
                report_failure("ack raised for a req while the aligner was idle");
            end
        end
        i_sym_req = 1'b0;
        next_cycle();
    endtask

    task automatic run_alignment(input string name, input query_t q, input int len,
                                 input logic slow, input logic poke_start);
        int best;
        int best_row;
        int best_col;
        align_reference(q, len, best, best_row, best_col);
        exp_name.push_back(name);
        exp_score.push_back(best);
        exp_row.push_back(best_row);
        exp_col.push_back(best_col);
        i_query = q;
        i_start = 1'b1;
        next_cycle();
        i_start = 1'b0;
        for (int i = 0; i < len; i++) begin
            // a second start mid-run with a different query
            if (poke_start && (i == len / 2)) begin
                i_query = ~q;
                i_start = 1'b1;
                next_cycle();
                i_start = 1'b0;
                i_query = q;
            end
            send_symbol(ref_buf[i], i == len - 1, slow);
        end
        wait_for_done();
    endtask

    function automatic query_t random_query();
        query_t q;
        for (int c = 0; c < `SW_NUM_PE; c++) begin
            q[c * `SW_BASE_W +: `SW_BASE_W] = base_t'(draw_bits(2));
        end
        return q;
    endfunction

    task automatic fill_random_ref(input int len);
        for (int i = 0; i < len; i++) begin
            ref_buf[i] = base_t'(draw_bits(2));
        end
    endtask

    task automatic copy_query_to_ref(input query_t q);
        for (int i = 0; i < `SW_NUM_PE; i++) begin
            ref_buf[i] = q[i * `SW_BASE_W +: `SW_BASE_W];
        end
    endtask

    initial begin : compare_results
        string name;
        forever begin
            @(negedge i_clk);
            if (o_done) begin
                if (exp_name.size() == 0) begin
                    report_failure("done pulsed with no run pending");
                end else begin
                    name = exp_name.pop_front();
                    check_value({name, " score"}, exp_score.pop_front(), o_max_score);
                    check_value({name, " row"}, exp_row.pop_front(), o_max_row);
                    check_value({name, " col"}, exp_col.pop_front(), o_max_col);
                end
            end
        end
    end

    // edges are judged against the req level seen before them
    initial begin : handshake_monitor
        logic prev_ack;
        logic prev_req;
        logic prev_busy;
        prev_ack  = 1'b0;
        prev_req  = 1'b0;
        prev_busy = 1'b0;
        forever begin
            @(negedge i_clk);
            if (!i_rst) begin
                if (prev_ack && !o_sym_ack && prev_req) begin
                    report_failure("ack fell while req was still high");
                end
                if (!prev_ack && o_sym_ack && !prev_req) begin
                    report_failure("ack rose without a pending req");
                end
                if (!prev_ack && o_sym_ack && !prev_busy) begin
                    report_failure("ack rose while the aligner was not running");
                end
            end
            prev_ack  = o_sym_ack;
            prev_req  = i_sym_req;
            prev_busy = o_busy;
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge i_clk);
        $display("timeout: the runs did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : stimulus
        query_t q;
        int     len;
        i_rst      = 1'b1;
        i_start    = 1'b0;
        i_query    = '0;
        i_sym_req  = 1'b0;
        i_sym      = '0;
        i_sym_last = 1'b0;
        lfsr_state = 32'h0551dd00;
        repeat (5) @(posedge i_clk);
        #(DRIVE_DELAY);
        i_rst = 1'b0;
        check_value("ack after reset", 0, o_sym_ack);
        check_value("busy after reset", 0, o_busy);
        check_value("done after reset", 0, o_done);
        probe_idle_request();

        q = random_query();
        copy_query_to_ref(q);
        run_alignment("identical", q, `SW_NUM_PE, 1'b0, 1'b0);
        check_value("identical score", `SW_NUM_PE * `SW_MATCH, o_max_score);
        check_value("identical row", `SW_NUM_PE, o_max_row);
        check_value("identical col", `SW_NUM_PE, o_max_col);

        // three bases inserted after the first half, none matching its diagonal
        for (int i = 0; i < `SW_NUM_PE; i++) begin
            q[i * `SW_BASE_W +: `SW_BASE_W] = base_t'(i % 4);
        end
        for (int i = 0; i < `SW_NUM_PE; i++) begin
            ref_buf[(i < `SW_NUM_PE / 2) ? i : i + 3] = q[i * `SW_BASE_W +: `SW_BASE_W];
        end
        ref_buf[`SW_NUM_PE / 2]     = 2'd3;
        ref_buf[`SW_NUM_PE / 2 + 1] = 2'd0;
        ref_buf[`SW_NUM_PE / 2 + 2] = 2'd1;
        run_alignment("affine gap", q, `SW_NUM_PE + 3, 1'b1, 1'b0);
        check_value("affine gap score",
                    `SW_NUM_PE * `SW_MATCH + `SW_GAP_OPEN + 2 * `SW_GAP_EXTEND, o_max_score);

        for (int t = 0; t < N_RANDOM; t++) begin
            len = 1 + draw_bits(6) % MAX_LEN;
            q   = random_query();
            fill_random_ref(len);
            run_alignment($sformatf("random %0d", t), q, len, 1'b1, 1'b0);
        end

        q = random_query();
        fill_random_ref(24);
        run_alignment("start while busy", q, 24, 1'b1, 1'b1);

        // high best first, then a short run that cannot reach it
        q = random_query();
        copy_query_to_ref(q);
        run_alignment("back to back first", q, `SW_NUM_PE, 1'b0, 1'b0);
        q = random_query();
        fill_random_ref(5);
        run_alignment("back to back second", q, 5, 1'b0, 1'b0);

        repeat (4) next_cycle();
        if (exp_name.size() != 0) begin
            report_failure("a run ended without its done pulse");
        end
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/pe_array.sv */
`default_nettype none

`include "sw_consts.svh"

module pe_array (
    input  wire                 i_clk,
    input  wire                 i_rst,
    input  wire                 i_start,
    input  wire sw_pkg::query_t i_query,
    input  wire                 i_step,
    input  wire sw_pkg::base_t  i_step_base,
    input  wire                 i_step_valid,
    output sw_pkg::score_vec_t  o_h_scores,
    output sw_pkg::lane_mask_t  o_lane_valid
);

    import sw_pkg::*;

    localparam int     N       = `SW_NUM_PE;
    localparam score_t NEG_INF = score_t'(`SW_NEG_INF);

    query_t     query_q;
    base_t      base_q [N];
    score_t     h_q [N];
    score_t     hd_q [N];
    score_t     e_q [N];
    score_t     f_q [N];
    // column 0 edge, H(r,0) and H(r-1,0)
    score_t     lb_h;
    score_t     lb_diag;

    // inputs seen by each lane on the current step
    base_t      base_in [N];
    lane_mask_t valid_in;
    score_t     h_new [N];
    score_t     e_new [N];
    score_t     f_new [N];

    assign valid_in = (o_lane_valid << 1) | lane_mask_t'(i_step_valid);

    genvar gj;
    generate
        for (gj = 0; gj < N; gj++) begin : g_lane
            score_t diag_in;
            score_t left_in;
            score_t e_left_in;

            if (gj == 0) begin : g_edge
                assign base_in[gj] = i_step_base;
                assign diag_in     = lb_diag;
                assign left_in     = lb_h;
                assign e_left_in   = NEG_INF;
            end else begin : g_chain
                // left neighbour finished this row one step earlier
                assign base_in[gj] = base_q[gj-1];
                assign diag_in     = hd_q[gj-1];
                assign left_in     = h_q[gj-1];
                assign e_left_in   = e_q[gj-1];
            end

            pe_cell u_cell (
                .i_a      (query_q[gj*`SW_BASE_W +: `SW_BASE_W]),
                .i_b      (base_in[gj]),
                .i_h_diag (diag_in),
                .i_h_top  (h_q[gj]),
                .i_h_left (left_in),
                .i_e_left (e_left_in),
                .i_f_top  (f_q[gj]),
                .o_h      (h_new[gj]),
                .o_e      (e_new[gj]),
                .o_f      (f_new[gj])
            );

            assign o_h_scores[gj*`SW_SCORE_W +: `SW_SCORE_W] = h_q[gj];
        end
    endgenerate

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_lane_valid <= '0;
        end else if (i_start) begin
            o_lane_valid <= '0;
        end else if (i_step) begin
            o_lane_valid <= valid_in;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start) begin
            query_q <= i_query;
            lb_h    <= score_t'(`SW_GAP_OPEN);
            lb_diag <= '0;
            for (int j = 0; j < N; j++) begin
                // top row boundary H(0,c)
                h_q[j]  <= score_t'(`SW_GAP_OPEN + `SW_GAP_EXTEND * j);
                hd_q[j] <= NEG_INF;
                e_q[j]  <= NEG_INF;
                f_q[j]  <= NEG_INF;
            end
        end else if (i_step) begin
            if (i_step_valid) begin
                lb_diag <= lb_h;
                lb_h    <= lb_h + score_t'(`SW_GAP_EXTEND);
            end
            for (int j = 0; j < N; j++) begin
                base_q[j] <= base_in[j];
                // idle lanes keep their last cell
                if (valid_in[j]) begin
                    hd_q[j] <= h_q[j];
                    h_q[j]  <= h_new[j];
                    e_q[j]  <= e_new[j];
                    f_q[j]  <= f_new[j];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/pe_cell.sv */
`default_nettype none

`include "sw_consts.svh"

module pe_cell (
    input  wire sw_pkg::base_t  i_a,
    input  wire sw_pkg::base_t  i_b,
    input  wire sw_pkg::score_t i_h_diag,
    input  wire sw_pkg::score_t i_h_top,
    input  wire sw_pkg::score_t i_h_left,
    input  wire sw_pkg::score_t i_e_left,
    input  wire sw_pkg::score_t i_f_top,
    output sw_pkg::score_t      o_h,
    output sw_pkg::score_t      o_e,
    output sw_pkg::score_t      o_f
);

    import sw_pkg::*;

    score_t sub;
    score_t e_ext;
    score_t e_open;
    score_t f_ext;
    score_t f_open;
    score_t h_diag;

    assign sub = (i_a == i_b) ? score_t'(`SW_MATCH) : score_t'(`SW_MISMATCH);

    // horizontal gap, extend or open from left H
    assign e_ext  = i_e_left + score_t'(`SW_GAP_EXTEND);
    assign e_open = i_h_left + score_t'(`SW_GAP_OPEN);
    assign o_e    = (e_ext > e_open) ? e_ext : e_open;

    // vertical gap from the cell above
    assign f_ext  = i_f_top + score_t'(`SW_GAP_EXTEND);
    assign f_open = i_h_top + score_t'(`SW_GAP_OPEN);
    assign o_f    = (f_ext > f_open) ? f_ext : f_open;

    assign h_diag = i_h_diag + sub;

    // signed three-way max
    always_comb begin
        o_h = h_diag;
        if (o_e > o_h) begin
            o_h = o_e;
        end
        if (o_f > o_h) begin
            o_h = o_f;
        end
    end

endmodule

`default_nettype wire

/* design/score_max_tracker.sv */
`default_nettype none

`include "sw_consts.svh"

module score_max_tracker (
    input  wire                 i_clk,
    input  wire                 i_rst,
    input  wire                 i_start,
    input  wire                 i_step,
    input  wire                 i_last_step,
    input  wire sw_pkg::score_t i_wave_max,
    input  wire sw_pkg::col_t   i_wave_col,
    input  wire                 i_wave_any,
    output sw_pkg::score_t      o_max_score,
    output sw_pkg::pos_t        o_max_row,
    output sw_pkg::col_t        o_max_col,
    output logic                o_done
);

    import sw_pkg::*;

    localparam score_t NEG_INF = score_t'(`SW_NEG_INF);

    pos_t step_cnt;
    // step index and end flag, two stages behind to meet the tree
    pos_t idx_d1;
    pos_t idx_d2;
    logic last_d1;
    logic last_d2;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            step_cnt    <= '0;
            last_d1     <= 1'b0;
            last_d2     <= 1'b0;
            o_done      <= 1'b0;
            o_max_score <= NEG_INF;
            o_max_row   <= '0;
            o_max_col   <= '0;
        end else begin
            last_d1 <= i_step && i_last_step;
            last_d2 <= last_d1;
            o_done  <= last_d2;
            if (i_start) begin
                step_cnt    <= '0;
                o_max_score <= NEG_INF;
                o_max_row   <= '0;
                o_max_col   <= '0;
            end else begin
                if (i_step) begin
                    step_cnt <= step_cnt + 1'b1;
                end
                // later wave wins a tie
                if (i_wave_any && (i_wave_max >= o_max_score)) begin
                    o_max_score <= i_wave_max;
                    o_max_col   <= i_wave_col;
                    // row = step - col + 2
                    o_max_row   <= idx_d2 + pos_t'(2) - pos_t'(i_wave_col);
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        idx_d1 <= step_cnt;
        idx_d2 <= idx_d1;
    end

    // the final wave reaches the tracker together with done
    a_done_after_wave: assert property (@(posedge i_clk) disable iff (i_rst)
        o_done |-> $past(i_wave_any));

endmodule

`default_nettype wire

/* design/sw_align_top.sv */
`default_nettype none

module sw_align_top (
    input  wire                 i_clk,
    input  wire                 i_rst,
    input  wire                 i_start,
    input  wire sw_pkg::query_t i_query,
    input  wire                 i_sym_req,
    input  wire sw_pkg::base_t  i_sym,
    input  wire                 i_sym_last,
    output logic                o_sym_ack,
    output logic                o_busy,
    output logic                o_done,
    output sw_pkg::score_t      o_max_score,
    output sw_pkg::pos_t        o_max_row,
    output sw_pkg::col_t        o_max_col
);

    import sw_pkg::*;

    logic       start_ok;
    logic       step;
    base_t      step_base;
    logic       step_valid;
    logic       last_step;
    score_vec_t h_scores;
    lane_mask_t lane_valid;
    score_t     wave_max;
    col_t       wave_col;
    logic       wave_any;

    // start during a run is dropped
    assign start_ok = i_start && !o_busy;

    symbol_intake u_intake (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_start      (start_ok),
        .i_sym_req    (i_sym_req),
        .i_sym        (i_sym),
        .i_sym_last   (i_sym_last),
        .o_sym_ack    (o_sym_ack),
        .o_busy       (o_busy),
        .o_step       (step),
        .o_step_base  (step_base),
        .o_step_valid (step_valid),
        .o_last_step  (last_step)
    );

    pe_array u_array (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_start      (start_ok),
        .i_query      (i_query),
        .i_step       (step),
        .i_step_base  (step_base),
        .i_step_valid (step_valid),
        .o_h_scores   (h_scores),
        .o_lane_valid (lane_valid)
    );

    wavefront_max u_wave_max (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_h_scores   (h_scores),
        .i_lane_valid (lane_valid),
        .i_step       (step),
        .o_wave_max   (wave_max),
        .o_wave_col   (wave_col),
        .o_wave_any   (wave_any)
    );

    score_max_tracker u_tracker (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_start      (start_ok),
        .i_step       (step),
        .i_last_step  (last_step),
        .i_wave_max   (wave_max),
        .i_wave_col   (wave_col),
        .i_wave_any   (wave_any),
        .o_max_score  (o_max_score),
        .o_max_row    (o_max_row),
        .o_max_col    (o_max_col),
        .o_done       (o_done)
    );

endmodule

`default_nettype wire

/* design/sw_consts.svh */
`ifndef SW_CONSTS_SVH
`define SW_CONSTS_SVH

// array geometry
`define SW_NUM_PE       16
`define SW_BASE_W       2
`define SW_SCORE_W      14
`define SW_POS_W        10
`define SW_COL_W        5

// longest reference stream accepted in one run
`define SW_MAX_REF_LEN  1000

// substitution scores
`define SW_MATCH        2
`define SW_MISMATCH     (-3)

// affine gap penalties
`define SW_GAP_OPEN     (-12)
`define SW_GAP_EXTEND   (-1)

// no path here
`define SW_NEG_INF      (-4096)

`endif

/* design/sw_pkg.sv */
`default_nettype none

`include "sw_consts.svh"

package sw_pkg;

    // signed cell score
    typedef logic signed [`SW_SCORE_W-1:0] score_t;

    typedef logic [`SW_BASE_W-1:0] base_t;

    // query base c-1 sits in slot c-1
    typedef logic [`SW_NUM_PE*`SW_BASE_W-1:0] query_t;

    typedef logic [`SW_POS_W-1:0] pos_t;

    // query column, 1..NUM_PE
    typedef logic [`SW_COL_W-1:0] col_t;

    typedef logic [`SW_NUM_PE-1:0] lane_mask_t;
    typedef logic [`SW_NUM_PE*`SW_SCORE_W-1:0] score_vec_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_REQ,
        WAIT_RELEASE,
        DRAIN
    } intake_state_t;

endpackage

`default_nettype wire

/* design/symbol_intake.sv */
`default_nettype none

`include "sw_consts.svh"

module symbol_intake (
    input  wire                i_clk,
    input  wire                i_rst,
    input  wire                i_start,
    input  wire                i_sym_req,
    input  wire sw_pkg::base_t i_sym,
    input  wire                i_sym_last,
    output logic               o_sym_ack,
    output logic               o_busy,
    output logic               o_step,
    output sw_pkg::base_t      o_step_base,
    output logic               o_step_valid,
    output logic               o_last_step
);

    import sw_pkg::*;

    localparam logic [`SW_COL_W-1:0] DRAIN_LAST = `SW_NUM_PE - 2;

    intake_state_t        state;
    pos_t                 row_cnt;
    logic [`SW_COL_W-1:0] drain_cnt;
    logic                 accept;

    // new req only counts once the previous ack is gone
    assign accept = (state == WAIT_REQ) && i_sym_req && !o_sym_ack;
    assign o_busy = (state != IDLE);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state        <= IDLE;
            row_cnt      <= '0;
            drain_cnt    <= '0;
            o_sym_ack    <= 1'b0;
            o_step       <= 1'b0;
            o_step_valid <= 1'b0;
            o_last_step  <= 1'b0;
        end else begin
            o_step      <= 1'b0;
            o_last_step <= 1'b0;
            // ack drops on the edge after req is seen low
            if (o_sym_ack && !i_sym_req) begin
                o_sym_ack <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (i_start) begin
                        state   <= WAIT_REQ;
                        row_cnt <= '0;
                    end
                end
                WAIT_REQ: begin
                    // step goes out on the same edge as ack
                    if (accept) begin
                        o_sym_ack    <= 1'b1;
                        o_step       <= 1'b1;
                        o_step_valid <= 1'b1;
                        row_cnt      <= row_cnt + 1'b1;
                        if (i_sym_last) begin
                            state     <= DRAIN;
                            drain_cnt <= '0;
                        end else begin
                            state <= WAIT_RELEASE;
                        end
                    end
                end
                WAIT_RELEASE: begin
                    if (!i_sym_req) begin
                        state <= WAIT_REQ;
                    end
                end
                DRAIN: begin
                    // push the last rows through the remaining columns
                    o_step       <= 1'b1;
                    o_step_valid <= 1'b0;
                    drain_cnt    <= drain_cnt + 1'b1;
                    if (drain_cnt == DRAIN_LAST) begin
                        o_last_step <= 1'b1;
                        state       <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_step_base <= i_sym;
        end
    end

    // producer raises a new req only after the previous ack has fallen
    a_req_after_ack: assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(i_sym_req) |-> !o_sym_ack);

    // reference stays within the row range
    a_ref_len: assert property (@(posedge i_clk) disable iff (i_rst)
        accept |-> (row_cnt < `SW_MAX_REF_LEN));

endmodule

`default_nettype wire

/* design/wavefront_max.sv */
`default_nettype none

`include "sw_consts.svh"

module wavefront_max (
    input  wire                     i_clk,
    input  wire                     i_rst,
    input  wire sw_pkg::score_vec_t i_h_scores,
    input  wire sw_pkg::lane_mask_t i_lane_valid,
    input  wire                     i_step,
    output sw_pkg::score_t          o_wave_max,
    output sw_pkg::col_t            o_wave_col,
    output logic                    o_wave_any
);

    import sw_pkg::*;

    localparam int     N       = `SW_NUM_PE;
    localparam int     LEAVES  = 1 << $clog2(N);
    localparam int     NODES   = 2 * LEAVES - 1;
    localparam score_t NEG_INF = score_t'(`SW_NEG_INF);

    score_t node_val [NODES];
    col_t   node_col [NODES];
    logic   step_q;

    // heap order, node k has children 2k+1 and 2k+2
    always_comb begin
        for (int k = 0; k < LEAVES; k++) begin
            if (k < N && i_lane_valid[k]) begin
                node_val[LEAVES-1+k] = i_h_scores[k*`SW_SCORE_W +: `SW_SCORE_W];
            end else begin
                node_val[LEAVES-1+k] = NEG_INF;
            end
            node_col[LEAVES-1+k] = col_t'(k + 1);
        end
        for (int k = LEAVES - 2; k >= 0; k--) begin
            // right child holds the higher lanes, so it takes ties
            if (node_val[2*k+2] >= node_val[2*k+1]) begin
                node_val[k] = node_val[2*k+2];
                node_col[k] = node_col[2*k+2];
            end else begin
                node_val[k] = node_val[2*k+1];
                node_col[k] = node_col[2*k+1];
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            step_q     <= 1'b0;
            o_wave_any <= 1'b0;
        end else begin
            step_q     <= i_step;
            o_wave_any <= step_q && (|i_lane_valid);
        end
    end

    // array outputs settle one edge after the step
    always_ff @(posedge i_clk) begin
        if (step_q) begin
            o_wave_max <= node_val[0];
            o_wave_col <= node_col[0];
        end
    end

endmodule

`default_nettype wire

/* sw_align_top.f */
+incdir+design
+incdir+bench
design/sw_pkg.sv
design/symbol_intake.sv
design/pe_cell.sv
design/pe_array.sv
design/wavefront_max.sv
design/score_max_tracker.sv
design/sw_align_top.sv
bench/sw_align_tb.sv
